//--- master_translator.f
+incdir+logic
logic/translator_pkg.sv
logic/command_framer.sv
logic/burst_sequencer.sv
logic/master_translator.sv
testbench/tb_master_translator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the master translator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
   --top-module tb_master_translator \
   -f master_translator.f \
   -o sim_tb

# the simulator exits nonzero on failure, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "** FAIL **" sim.log; then
   echo "simulation failed"
   exit 1
fi

echo "simulation passed"

//--- testbench/tb_master_translator.sv
`timescale 1ns/1ps
`include "translator_settings.svh"

module tb_master_translator;

   import translator_pkg::*;

   localparam int num_bursts  = 200;
   localparam int max_len     = 8;
   localparam int stall_bound = 3;
   localparam int max_gap     = 3;
   // worst beat waits out the stall bound, doubled for gaps and read drain
   localparam int timeout_cycles = 2 * num_bursts * (max_len * (stall_bound + 1) + max_gap + 1);

   localparam logic [`FABRIC_ADDR_W-1:0]  addr_step  = `BYTES_PER_WORD;
   localparam logic [`FABRIC_BURST_W-1:0] count_step = `BYTES_PER_WORD;

   logic        clk;
   logic        reset;
   local_cmd_t  local_cmd;
   logic        local_waitrequest;
   rsp_t        local_rsp;
   fabric_cmd_t fabric_cmd;
   logic        fabric_waitrequest;
   rsp_t        fabric_rsp;
   logic        active;

   // reference state of the burst on the bus
   logic [`LOCAL_ADDR_W-1:0]   exp_base;
   logic [3:0]                 beat_idx;
   int                         bursts_done;
   logic [`FABRIC_ADDR_W-1:0]  exp_addr;
   logic [`FABRIC_BURST_W-1:0] exp_count;

   // last cycle's command, for the stall checks
   logic                       stall_held;
   logic [`FABRIC_ADDR_W-1:0]  prev_addr;
   logic [`FABRIC_BURST_W-1:0] prev_count;

   // fabric slave model
   logic [`DATA_W-1:0]         mem [64];
   logic [`LOCAL_ADDR_W-1:0]   pending [$];
   logic [`LOCAL_ADDR_W-1:0]   word_idx;
   int                         beat_words;
   int                         stall_run;
   int                         lane;
   int                         fill_idx;
   int                         cycle_count;
   logic [31:0]                rand_word;

   master_translator uut (
      .clk                (clk),
      .reset              (reset),
      .local_cmd          (local_cmd),
      .local_waitrequest  (local_waitrequest),
      .local_rsp          (local_rsp),
      .fabric_cmd         (fabric_cmd),
      .fabric_waitrequest (fabric_waitrequest),
      .fabric_rsp         (fabric_rsp)
   );

   always #10 clk = ~clk;

   assign active = fabric_cmd.write | fabric_cmd.read;

   // --------------------
   // reference model
   // --------------------

   // base times word size, plus one word per beat already taken
   function automatic logic [`FABRIC_ADDR_W-1:0] beat_addr(
      input logic [`LOCAL_ADDR_W-1:0] base,
      input logic [3:0]               k
   );
      logic [`FABRIC_ADDR_W-1:0] base_wide;
      logic [`FABRIC_ADDR_W-1:0] k_wide;
      base_wide = '0;
      base_wide[`LOCAL_ADDR_W-1:0] = base;
      k_wide = '0;
      k_wide[3:0] = k;
      return base_wide * addr_step + k_wide * addr_step;
   endfunction

   function automatic logic [`FABRIC_BURST_W-1:0] remaining_bytes(
      input logic [3:0] len,
      input logic [3:0] k
   );
      logic [`FABRIC_BURST_W-1:0] words_left;
      words_left = '0;
      words_left[3:0] = len - k;
      return words_left * count_step;
   endfunction

   task automatic report_mismatch(
      input string       name,
      input logic [63:0] expected,
      input logic [63:0] actual
   );
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
   endtask

   // --------------------
   // local master
   // --------------------

   task automatic go_idle(input int cycles);
      local_cmd.write = 1'b0;
      local_cmd.read  = 1'b0;
      repeat (cycles) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic present_beat(input logic is_read, input logic [3:0] len, input logic [3:0] k);
      rand_word = $urandom;
      local_cmd.write      = ~is_read;
      local_cmd.read       = is_read;
      local_cmd.address    = exp_base;
      local_cmd.burstcount = len;
      local_cmd.byteenable = rand_word[3:0];
      local_cmd.writedata  = $urandom;
      beat_idx  = k;
      exp_addr  = beat_addr(exp_base, k);
      exp_count = remaining_bytes(len, k);
      // hold until the fabric takes the beat
      do begin
         @(posedge clk);
      end while (fabric_waitrequest);
      #1;
   endtask

   task automatic run_burst;
      logic       is_read;
      logic [3:0] len;
      logic [3:0] k;
      rand_word = $urandom;
      is_read   = rand_word[0];
      len       = {1'b0, rand_word[6:4]} + 4'd1;
      rand_word = $urandom;
      exp_base  = rand_word[`LOCAL_ADDR_W-1:0];
      if (is_read) begin
         present_beat(1'b1, len, 4'd0);
      end else begin
         for (k = 4'd0; k < len; k++) begin
            present_beat(1'b0, len, k);
         end
      end
      bursts_done++;
      rand_word = $urandom;
      go_idle(rand_word[1:0]);
   endtask

   initial begin
      void'($urandom(32'h3565));
      clk                = 1'b0;
      reset              = 1'b1;
      local_cmd          = '0;
      fabric_waitrequest = 1'b0;
      fabric_rsp         = '0;
      exp_base           = '0;
      beat_idx           = '0;
      bursts_done        = 0;
      exp_addr           = '0;
      exp_count          = '0;
      stall_held         = 1'b0;
      stall_run          = 0;
      cycle_count        = 0;
      for (fill_idx = 0; fill_idx < 64; fill_idx++) begin
         mem[fill_idx] = 32'h9e37_79b9 * (fill_idx + 1);
      end
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      repeat (num_bursts) run_burst();

      // let outstanding read data drain
      while (pending.size() != 0) go_idle(1);
      go_idle(4);

      $display("** PASS **");
      $finish;
   end

   // --------------------
   // fabric slave
   // --------------------

   always @(posedge clk) begin
      if (!reset && active && !fabric_waitrequest) begin
         word_idx = fabric_cmd.address.split.word;
         if (fabric_cmd.write) begin
            for (lane = 0; lane < `BYTES_PER_WORD; lane++) begin
               if (fabric_cmd.byteenable[lane]) begin
                  mem[word_idx[5:0]][lane*8 +: 8] = fabric_cmd.writedata[lane*8 +: 8];
               end
            end
         end else begin
            beat_words = fabric_cmd.burstcount >> `LANE_W;
            for (lane = 0; lane < beat_words; lane++) begin
               pending.push_back(word_idx);
               word_idx = word_idx + 1'b1;
            end
         end
      end
      #1;
      // read data comes back a random number of cycles later
      if (pending.size() != 0 && ($urandom % 4) != 0) begin
         word_idx                 = pending.pop_front();
         fabric_rsp.readdata      = mem[word_idx[5:0]];
         fabric_rsp.readdatavalid = 1'b1;
      end else begin
         fabric_rsp.readdatavalid = 1'b0;
      end
      if (stall_run < stall_bound && ($urandom % 3) == 0) begin
         fabric_waitrequest = 1'b1;
         stall_run++;
      end else begin
         fabric_waitrequest = 1'b0;
         stall_run = 0;
      end
   end

   always @(posedge clk) begin
      stall_held <= !reset && active && fabric_waitrequest;
      prev_addr  <= fabric_cmd.address.byte_addr;
      prev_count <= fabric_cmd.burstcount;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > timeout_cycles) begin
         $display("Error at %0t ns: run hung, test did not end within %0d cycles",
                  $time, timeout_cycles);
         $display("** FAIL **");
         $fatal(1, "timeout");
      end
   end

   // --------------------
   // checks
   // --------------------

   check_addr: assert property (@(posedge clk) disable iff (reset)
      active |-> fabric_cmd.address.byte_addr == exp_addr)
      else report_mismatch("fabric_cmd.address", 64'($sampled(exp_addr)),
                           64'($sampled(fabric_cmd.address.byte_addr)));

   check_count: assert property (@(posedge clk) disable iff (reset)
      active |-> fabric_cmd.burstcount == exp_count)
      else report_mismatch("fabric_cmd.burstcount", 64'($sampled(exp_count)),
                           64'($sampled(fabric_cmd.burstcount)));

   // read and write levels follow the local master
   check_dir: assert property (@(posedge clk) disable iff (reset)
      {fabric_cmd.write, fabric_cmd.read} == {local_cmd.write, local_cmd.read})
      else report_mismatch("fabric_cmd.write/read",
                           64'($sampled({local_cmd.write, local_cmd.read})),
                           64'($sampled({fabric_cmd.write, fabric_cmd.read})));

   check_wdata: assert property (@(posedge clk) disable iff (reset)
      fabric_cmd.write |-> fabric_cmd.writedata == local_cmd.writedata)
      else report_mismatch("fabric_cmd.writedata", 64'($sampled(local_cmd.writedata)),
                           64'($sampled(fabric_cmd.writedata)));

   check_be: assert property (@(posedge clk) disable iff (reset)
      active |-> fabric_cmd.byteenable == local_cmd.byteenable)
      else report_mismatch("fabric_cmd.byteenable", 64'($sampled(local_cmd.byteenable)),
                           64'($sampled(fabric_cmd.byteenable)));

   check_rsp: assert property (@(posedge clk) local_rsp == fabric_rsp)
      else report_mismatch("local_rsp", 64'($sampled(fabric_rsp)), 64'($sampled(local_rsp)));

   check_wait: assert property (@(posedge clk) local_waitrequest == fabric_waitrequest)
      else report_mismatch("local_waitrequest", 64'($sampled(fabric_waitrequest)),
                           64'($sampled(local_waitrequest)));

   // a stalled beat keeps its address and count
   check_stall_addr: assert property (@(posedge clk) disable iff (reset)
      stall_held |-> fabric_cmd.address.byte_addr == prev_addr)
      else report_mismatch("fabric_cmd.address", 64'($sampled(prev_addr)),
                           64'($sampled(fabric_cmd.address.byte_addr)));

   check_stall_count: assert property (@(posedge clk) disable iff (reset)
      stall_held |-> fabric_cmd.burstcount == prev_count)
      else report_mismatch("fabric_cmd.burstcount", 64'($sampled(prev_count)),
                           64'($sampled(fabric_cmd.burstcount)));

   // new burst starts from its own base
   check_restart: assert property (@(posedge clk) disable iff (reset)
      active && beat_idx == 4'd0 && bursts_done != 0
         |-> fabric_cmd.address.byte_addr == beat_addr(exp_base, 4'd0))
      else report_mismatch("fabric_cmd.address", 64'(beat_addr($sampled(exp_base), 4'd0)),
                           64'($sampled(fabric_cmd.address.byte_addr)));

endmodule

//--- logic/master_translator.sv
`timescale 1ns/1ps

module master_translator (
   input  logic                        clk,
   input  logic                        reset,

   // local master side
   input  translator_pkg::local_cmd_t  local_cmd,
   output logic                        local_waitrequest,
   output translator_pkg::rsp_t        local_rsp,

   // fabric side
   output translator_pkg::fabric_cmd_t fabric_cmd,
   input  logic                        fabric_waitrequest,
   input  translator_pkg::rsp_t        fabric_rsp
);

   import translator_pkg::*;

   fabric_cmd_t scaled_cmd;
   logic        begin_transfer;
   logic        begin_burst;
   logic        last_beat;

   // --------------------
   // command path
   // --------------------

   command_framer u_framer (
      .clk                (clk),
      .reset              (reset),
      .local_cmd          (local_cmd),
      .fabric_waitrequest (fabric_waitrequest),
      .last_beat          (last_beat),
      .scaled_cmd         (scaled_cmd),
      .begin_transfer     (begin_transfer),
      .begin_burst        (begin_burst)
   );

   burst_sequencer u_sequencer (
      .clk                (clk),
      .reset              (reset),
      .scaled_cmd         (scaled_cmd),
      .begin_transfer     (begin_transfer),
      .begin_burst        (begin_burst),
      .fabric_waitrequest (fabric_waitrequest),
      .fabric_cmd         (fabric_cmd),
      .last_beat          (last_beat)
   );

   // --------------------
   // return path
   // --------------------

   // stall and read data go back unchanged, same cycle
   assign local_waitrequest = fabric_waitrequest;
   assign local_rsp         = fabric_rsp;

endmodule

//--- logic/burst_sequencer.sv
`timescale 1ns/1ps
`include "translator_settings.svh"

module burst_sequencer (
   input  logic                        clk,
   input  logic                        reset,
   input  translator_pkg::fabric_cmd_t scaled_cmd,
   input  logic                        begin_transfer,
   input  logic                        begin_burst,
   input  logic                        fabric_waitrequest,
   output translator_pkg::fabric_cmd_t fabric_cmd,
   output logic                        last_beat
);

   import translator_pkg::*;

   localparam logic [`FABRIC_BURST_W-1:0] word_bytes = `BYTES_PER_WORD;

   // tracked state of the burst in flight
   fabric_addr_u                addr_q;
   logic [`FABRIC_BURST_W-1:0]  count_q;
   logic                        first_stalled;
   logic                        beat_stalled;

   // one word on from the scaled and from the tracked address
   fabric_addr_u                first_next_addr;
   fabric_addr_u                tracked_next_addr;

   // --------------------
   // next address
   // --------------------

   // step the word index, lane bits ride along
   always_comb begin
      first_next_addr            = scaled_cmd.address;
      first_next_addr.split.word = scaled_cmd.address.split.word + 1'b1;
   end

   always_comb begin
      tracked_next_addr            = addr_q;
      tracked_next_addr.split.word = addr_q.split.word + 1'b1;
   end

   // --------------------
   // tracking registers
   // --------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_q        <= '0;
         count_q       <= '0;
         first_stalled <= 1'b0;
         beat_stalled  <= 1'b0;
      end else begin
         if (begin_burst || first_stalled) begin
            // first beat, start from the scaled command
            if (fabric_waitrequest) begin
               first_stalled <= 1'b1;
               addr_q        <= scaled_cmd.address;
               count_q       <= scaled_cmd.burstcount;
            end else begin
               first_stalled <= 1'b0;
               addr_q        <= first_next_addr;
               count_q       <= scaled_cmd.burstcount - word_bytes;
            end
         end else if (begin_transfer || beat_stalled) begin
            // later beats move only when accepted
            if (!fabric_waitrequest) begin
               beat_stalled <= 1'b0;
               addr_q       <= tracked_next_addr;
               count_q      <= count_q - word_bytes;
            end else begin
               beat_stalled <= 1'b1;
            end
         end
      end
   end

   // --------------------
   // fabric command
   // --------------------

   // scaled values on a burst's first beat, tracked values after it
   always_comb begin
      fabric_cmd = scaled_cmd;
      if (!begin_burst) begin
         fabric_cmd.address    = addr_q;
         fabric_cmd.burstcount = count_q;
      end
   end

   // one word left in whichever count goes out
   assign last_beat = begin_burst ? (scaled_cmd.burstcount == word_bytes)
                                  : (count_q == word_bytes);

   // --------------------
   // checks
   // --------------------

   // a zero count would mean the tracking ran past the end of a burst
   property count_nonzero;
      @(posedge clk) disable iff (reset)
         (fabric_cmd.write || fabric_cmd.read) |-> (fabric_cmd.burstcount != '0);
   endproperty

   assert property (count_nonzero)
      else $error("fabric burstcount is zero on an active command");

endmodule

//--- logic/command_framer.sv
`timescale 1ns/1ps
`include "translator_settings.svh"

module command_framer (
   input  logic                        clk,
   input  logic                        reset,
   input  translator_pkg::local_cmd_t  local_cmd,
   input  logic                        fabric_waitrequest,
   input  logic                        last_beat,
   output translator_pkg::fabric_cmd_t scaled_cmd,
   output logic                        begin_transfer,
   output logic                        begin_burst
);

   import translator_pkg::*;

   fabric_addr_u byte_addr;
   logic         request;
   logic         end_transfer;
   logic         end_burst;

   // --------------------
   // scaling
   // --------------------

   // word index straight in, lane bits zero
   always_comb begin
      byte_addr.split.word = local_cmd.address;
      byte_addr.split.lane = '0;
   end

   always_comb begin
      scaled_cmd.write      = local_cmd.write;
      scaled_cmd.read       = local_cmd.read;
      scaled_cmd.address    = byte_addr;
      // words to bytes, shift by the lane width
      scaled_cmd.burstcount = {local_cmd.burstcount, {`LANE_W{1'b0}}};
      scaled_cmd.byteenable = local_cmd.byteenable;
      scaled_cmd.writedata  = local_cmd.writedata;
   end

   assign request = scaled_cmd.write | scaled_cmd.read;

   // --------------------
   // begin-transfer
   // --------------------

   // only the first cycle of a beat, low while it stalls
   assign begin_transfer = request & ~end_transfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_transfer <= 1'b0;
      end else begin
         if (begin_transfer && fabric_waitrequest) begin
            end_transfer <= 1'b1;
         end else if (!fabric_waitrequest) begin
            end_transfer <= 1'b0;
         end
      end
   end

   // --------------------
   // begin-burst
   // --------------------

   // every read opens its own burst
   assign begin_burst = scaled_cmd.read ? begin_transfer : begin_transfer & ~end_burst;

   // set inside a write burst, cleared once the last beat starts
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_burst <= 1'b0;
      end else begin
         if ((last_beat && begin_transfer) || scaled_cmd.read) begin
            end_burst <= 1'b0;
         end else if (scaled_cmd.write && begin_transfer) begin
            end_burst <= 1'b1;
         end
      end
   end

   // --------------------
   // checks
   // --------------------

   // local master must keep its request still until the fabric takes it,
   // otherwise the tracked burst no longer matches the command
   property hold_while_stalled;
      @(posedge clk) disable iff (reset)
         (request && fabric_waitrequest) |=> $stable(local_cmd);
   endproperty

   assert property (hold_while_stalled)
      else $error("local command changed while waitrequest was high");

endmodule

//--- logic/translator_pkg.sv
`include "translator_settings.svh"

package translator_pkg;

   // --------------------
   // local master request
   // --------------------

   typedef struct packed {
      logic                         write;
      logic                         read;
      logic [`LOCAL_ADDR_W-1:0]     address;
      logic [`LOCAL_BURST_W-1:0]    burstcount;
      logic [`BYTES_PER_WORD-1:0]   byteenable;
      logic [`DATA_W-1:0]           writedata;
   } local_cmd_t;

   // --------------------
   // fabric address views
   // --------------------

   // word index on top, byte lane in the low bits
   typedef struct packed {
      logic [`LOCAL_ADDR_W-1:0]     word;
      logic [`LANE_W-1:0]           lane;
   } fabric_split_t;

   // the sequencer steps the word index, the fabric sees bytes
   typedef union packed {
      logic [`FABRIC_ADDR_W-1:0]    byte_addr;
      fabric_split_t                split;
   } fabric_addr_u;

   // --------------------
   // fabric command
   // --------------------

   typedef struct packed {
      logic                         write;
      logic                         read;
      fabric_addr_u                 address;
      logic [`FABRIC_BURST_W-1:0]   burstcount;
      logic [`BYTES_PER_WORD-1:0]   byteenable;
      logic [`DATA_W-1:0]           writedata;
   } fabric_cmd_t;

   // read response, same shape on both sides
   typedef struct packed {
      logic [`DATA_W-1:0]           readdata;
      logic                         readdatavalid;
   } rsp_t;

endpackage

//--- logic/translator_settings.svh
`ifndef TRANSLATOR_SETTINGS_SVH
`define TRANSLATOR_SETTINGS_SVH

// --------------------
// local master side
// --------------------

// word address width
`define LOCAL_ADDR_W 24

`define DATA_W 32

// burst of 1 to 8 words
`define LOCAL_BURST_W 4

// --------------------
// fabric side
// --------------------

`define BYTES_PER_WORD 4
`define LANE_W 2

// byte address keeps the lane bits below the word index
`define FABRIC_ADDR_W (`LOCAL_ADDR_W + `LANE_W)
`define FABRIC_BURST_W 6

`endif
